//--- source/eeprom_params.svh
`ifndef EEPROM_PARAMS_SVH
`define EEPROM_PARAMS_SVH

// 24C16 class part, 2 KB seen as eight 256-byte blocks
`define EE_ADDR_WIDTH   11
`define EE_DATA_WIDTH   8

// upper address bits, carried in the control byte
`define EE_BLOCK_WIDTH  3

`define EE_DEVICE_CODE  4'b1010     // device type code

`endif

//--- source/eeprom_bus_pkg.sv
`include "eeprom_params.svh"

package eeprom_bus_pkg;

    // last bit of the control byte
    typedef enum logic {
        rw_write = 1'b0,
        rw_read  = 1'b1
    } rw_e;

    // field order is wire order, msb first
    typedef struct packed {
        logic [`EE_DATA_WIDTH-`EE_BLOCK_WIDTH-2:0] code;    // device type
        logic [`EE_BLOCK_WIDTH-1:0]                block;   // addr[10:8]
        rw_e                                       rw;
    } ctrl_fields_s;

    // built from fields, shifted out as a plain byte
    typedef union packed {
        logic [`EE_DATA_WIDTH-1:0] raw;
        ctrl_fields_s              f;
    } ctrl_byte_u;

endpackage

//--- source/eeprom_ctrl_pkg.sv
package eeprom_ctrl_pkg;

    // one-hot, one state per step on the bus
    typedef enum logic [9:0] {
        idle        = 10'b00_0000_0001,
        write_start = 10'b00_0000_0010,
        ctrl_write  = 10'b00_0000_0100,
        addr_write  = 10'b00_0000_1000,
        data_write  = 10'b00_0001_0000,
        read_start  = 10'b00_0010_0000,
        ctrl_read   = 10'b00_0100_0000,
        data_read   = 10'b00_1000_0000,
        stop        = 10'b01_0000_0000,
        ackn        = 10'b10_0000_0000
    } seq_state_e;

    typedef enum logic [1:0] {
        op_start = 2'd0,
        op_send  = 2'd1,
        op_recv  = 2'd2,
        op_stop  = 2'd3
    } engine_op_e;

endpackage

//--- source/serial_cmd_if.sv
`timescale 1ns/1ps
`include "eeprom_params.svh"

interface serial_cmd_if
    import eeprom_ctrl_pkg::*;
();

    logic                      go;        // single cycle, engine idle
    engine_op_e                op;
    logic [`EE_DATA_WIDTH-1:0] tx_byte;
    logic                      done;      // single cycle
    logic [`EE_DATA_WIDTH-1:0] rx_byte;   // held from done on

    modport seq (
        output go,
        output op,
        output tx_byte,
        input  done,
        input  rx_byte
    );

    modport eng (
        input  go,
        input  op,
        input  tx_byte,
        output done,
        output rx_byte
    );

endinterface

//--- source/eeprom_sequencer.sv
`timescale 1ns/1ps
`include "eeprom_params.svh"

module eeprom_sequencer
    import eeprom_bus_pkg::*;
    import eeprom_ctrl_pkg::*;
(
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      wr,
    input  logic                      rd,
    input  logic [`EE_ADDR_WIDTH-1:0] addr,
    input  logic [`EE_DATA_WIDTH-1:0] wr_data,
    output logic [`EE_DATA_WIDTH-1:0] rd_data,
    output logic                      ack,
    serial_cmd_if.seq                 cmd
);

    seq_state_e                state;
    seq_state_e                next_state;
    rw_e                       dir;         // latched command
    logic                      accept;
    logic [`EE_ADDR_WIDTH-1:0] addr_q;
    logic [`EE_DATA_WIDTH-1:0] data_q;
    ctrl_byte_u                ctrl;

    assign accept = (state == idle) && (wr || rd);

    // control byte, rw set only for the byte after the repeated start
    always_comb
    begin
        ctrl.f.code  = `EE_DEVICE_CODE;
        ctrl.f.block = addr_q[`EE_ADDR_WIDTH-1 -: `EE_BLOCK_WIDTH];
        ctrl.f.rw    = (state == read_start) ? rw_read : rw_write;
    end

    // next op goes out in the cycle done is seen, so frames stay back to back
    always_comb
    begin
        next_state  = state;
        cmd.go      = 1'b0;
        cmd.op      = op_send;
        cmd.tx_byte = ctrl.raw;
        case (state)
            idle:
                if (accept)
                begin
                    cmd.go     = 1'b1;
                    cmd.op     = op_start;
                    next_state = write_start;
                end
            write_start:
                if (cmd.done)
                begin
                    cmd.go     = 1'b1;
                    next_state = ctrl_write;
                end
            ctrl_write:
                if (cmd.done)
                begin
                    cmd.go      = 1'b1;
                    cmd.tx_byte = addr_q[`EE_DATA_WIDTH-1:0];     // word address
                    next_state  = addr_write;
                end
            addr_write:
                if (cmd.done)
                begin
                    cmd.go = 1'b1;
                    if (dir == rw_read)
                    begin
                        cmd.op     = op_start;      // repeated start
                        next_state = read_start;
                    end
                    else
                    begin
                        cmd.tx_byte = data_q;
                        next_state  = data_write;
                    end
                end
            read_start:
                if (cmd.done)
                begin
                    cmd.go     = 1'b1;
                    next_state = ctrl_read;
                end
            ctrl_read:
                if (cmd.done)
                begin
                    cmd.go     = 1'b1;
                    cmd.op     = op_recv;
                    next_state = data_read;
                end
            data_write, data_read:
                if (cmd.done)
                begin
                    cmd.go     = 1'b1;
                    cmd.op     = op_stop;
                    next_state = stop;
                end
            stop:
                if (cmd.done)
                    next_state = ackn;
            ackn:
                next_state = idle;
            default:
                next_state = idle;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= idle;
            dir   <= rw_write;
            ack   <= 1'b0;
        end
        else
        begin
            state <= next_state;
            ack   <= (state == stop) && cmd.done;       // high for the ackn cycle
            if (accept)
                dir <= wr ? rw_write : rw_read;         // wr wins
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            addr_q <= addr;
            data_q <= wr_data;
        end
        if ((state == data_read) && cmd.done)
            rd_data <= cmd.rx_byte;     // kept until the next read
    end

endmodule

//--- source/serial_bit_engine.sv
`timescale 1ns/1ps
`include "eeprom_params.svh"

module serial_bit_engine
    import eeprom_ctrl_pkg::*;
(
    input  logic      CLK,
    input  logic      RESET,
    serial_cmd_if.eng cmd,
    output logic      scl,
    output logic      sda_out,
    output logic      sda_oe,
    input  logic      sda_in
);

    localparam int last_step = 2 * `EE_DATA_WIDTH - 1;    // two clk edges per bit
    localparam int step_w    = $clog2(last_step + 1);
    localparam int msb       = `EE_DATA_WIDTH - 1;

    logic                      busy;
    logic                      pend;        // go arrived in an scl high phase
    logic                      launch;
    logic [step_w-1:0]         step;
    engine_op_e                op_q;
    engine_op_e                act_op;
    logic [`EE_DATA_WIDTH-1:0] shreg;
    logic [`EE_DATA_WIDTH-1:0] act_byte;
    logic                      done_q;
    logic [`EE_DATA_WIDTH-1:0] rx_q;

    // clk/2 on the falling edge, so sda moves in the middle of an scl phase
    always_ff @(negedge CLK)
    begin
        if (RESET)
            scl <= 1'b0;
        else
            scl <= ~scl;
    end

    // every op begins on an edge inside an scl low phase
    assign act_op   = pend ? op_q : cmd.op;
    assign act_byte = pend ? shreg : cmd.tx_byte;
    assign launch   = (cmd.go || pend) && !busy && !scl;

    assign cmd.done    = done_q;
    assign cmd.rx_byte = rx_q;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy    <= 1'b0;
            pend    <= 1'b0;
            step    <= '0;
            done_q  <= 1'b0;
            sda_oe  <= 1'b0;
            sda_out <= 1'b1;
        end
        else
        begin
            done_q <= 1'b0;
            if (launch)
            begin
                pend <= 1'b0;
                busy <= 1'b1;
                step <= step_w'(1);
                case (act_op)
                    op_start:
                    begin
                        sda_oe  <= 1'b1;
                        sda_out <= 1'b1;        // high before scl rises
                    end
                    op_stop:
                    begin
                        sda_oe  <= 1'b1;
                        sda_out <= 1'b0;
                    end
                    op_send:
                    begin
                        sda_oe  <= 1'b1;
                        sda_out <= act_byte[msb];
                    end
                    default:
                        sda_oe <= 1'b0;         // recv, slave drives
                endcase
            end
            else if (busy)
            begin
                step <= step + step_w'(1);
                case (op_q)
                    op_start:
                    begin
                        sda_out <= 1'b0;        // falls with scl high
                        busy    <= 1'b0;
                        done_q  <= 1'b1;
                    end
                    op_stop:
                    begin
                        sda_oe  <= 1'b0;        // pull-up takes sda high, scl high
                        sda_out <= 1'b1;
                        busy    <= 1'b0;
                        done_q  <= 1'b1;
                    end
                    default:
                        if (step == step_w'(last_step))
                        begin
                            busy   <= 1'b0;
                            done_q <= 1'b1;
                        end
                        else if (!scl && (op_q == op_send))
                            sda_out <= shreg[msb];
                endcase
            end
            else if (cmd.go)
                pend <= 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (launch)
        begin
            op_q  <= act_op;
            shreg <= {act_byte[msb-1:0], 1'b0};
        end
        else if (busy)
        begin
            if ((op_q == op_send) && !scl)
                shreg <= {shreg[msb-1:0], 1'b0};
            else if ((op_q == op_recv) && scl)
                shreg <= {shreg[msb-1:0], sda_in};     // sampled mid high phase
            if ((op_q == op_recv) && (step == step_w'(last_step)))
                rx_q <= {shreg[msb-1:0], sda_in};
        end
        else if (cmd.go)
        begin
            op_q  <= cmd.op;
            shreg <= cmd.tx_byte;
        end
    end

endmodule

//--- source/eeprom_ctrl_top.sv
`timescale 1ns/1ps
`include "eeprom_params.svh"

module eeprom_ctrl_top
(
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      wr,
    input  logic                      rd,
    input  logic [`EE_ADDR_WIDTH-1:0] addr,
    input  logic [`EE_DATA_WIDTH-1:0] wr_data,
    output logic [`EE_DATA_WIDTH-1:0] rd_data,
    output logic                      ack,
    output logic                      scl,
    inout  wire                       sda
);

    logic sda_out;
    logic sda_oe;

    serial_cmd_if cmd ();

    eeprom_sequencer u_seq (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .rd_data (rd_data),
        .ack     (ack),
        .cmd     (cmd)
    );

    serial_bit_engine u_eng (
        .CLK     (CLK),
        .RESET   (RESET),
        .cmd     (cmd),
        .scl     (scl),
        .sda_out (sda_out),
        .sda_oe  (sda_oe),
        .sda_in  (sda)
    );

    assign sda = sda_oe ? sda_out : 1'bz;     // released, pull-up holds high

endmodule

//--- tests/eeprom_model.sv
`timescale 1ns/1ps
`include "eeprom_params.svh"

module eeprom_model
    import eeprom_bus_pkg::*;
(
    input  logic scl,
    inout  wire  sda
);

    logic [`EE_DATA_WIDTH-1:0] mem [0:(1 << `EE_ADDR_WIDTH)-1];
    logic [`EE_DATA_WIDTH-1:0] shreg;
    logic [`EE_DATA_WIDTH-1:0] tx;
    logic [`EE_DATA_WIDTH-1:0] ptr;
    ctrl_byte_u                ctrl;
    int                        bit_cnt;
    int                        byte_idx;
    int                        tx_cnt;
    logic                      load_tx;
    logic                      drive_en;
    logic                      drive_bit;

    // open drain, a one is left to the pull-up
    assign sda = (drive_en && !drive_bit) ? 1'b0 : 1'bz;

    initial
    begin
        for (int i = 0; i < (1 << `EE_ADDR_WIDTH); i++)
            mem[i] = 8'hff;
        ptr      = '0;
        bit_cnt  = 0;
        byte_idx = 0;
        tx_cnt   = 0;
        load_tx  = 1'b0;
        drive_en = 1'b0;
    end

    task automatic take_byte(input logic [`EE_DATA_WIDTH-1:0] b);
        case (byte_idx)
            0:
            begin
                ctrl.raw = b;
                if (ctrl.f.code == `EE_DEVICE_CODE && ctrl.f.rw == rw_read)
                begin
                    tx      = mem[{ctrl.f.block, ptr}];
                    load_tx = 1'b1;
                end
            end
            1: ptr = b;     // word address
            2: mem[{ctrl.f.block, ptr}] = b;
            default: ;
        endcase
        byte_idx++;
    endtask

    // start or stop, both restart byte framing
    always @(sda)
        if (scl === 1'b1 && (sda === 1'b0 || sda === 1'b1))
        begin
            bit_cnt  = 0;
            byte_idx = 0;
        end

    always @(posedge scl)
        if (!load_tx && !drive_en)
        begin
            shreg = {shreg[`EE_DATA_WIDTH-2:0], sda === 1'b1};
            bit_cnt++;
            if (bit_cnt == `EE_DATA_WIDTH)
            begin
                bit_cnt = 0;
                take_byte(shreg);
            end
        end

    always @(negedge scl)
        if (drive_en && tx_cnt == `EE_DATA_WIDTH)
            drive_en = 1'b0;
        else if (load_tx || drive_en)
        begin
            tx_cnt = load_tx ? 1 : tx_cnt + 1;
            #60;        // after the master lets go of sda
            drive_bit = tx[`EE_DATA_WIDTH-1];
            tx        = {tx[`EE_DATA_WIDTH-2:0], 1'b0};
            drive_en  = 1'b1;
            load_tx   = 1'b0;
        end

endmodule

//--- tests/eeprom_checker.sv
`timescale 1ns/1ps
`include "eeprom_params.svh"

module eeprom_checker
    import eeprom_bus_pkg::*;
(
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      ack,
    input  logic [`EE_DATA_WIDTH-1:0] rd_data,
    input  logic                      scl,
    input  wire                       sda
);

    localparam int tok_start = 256;
    localparam int tok_stop  = 257;

    int                        exp_tok [$];
    logic                      exp_read [$];
    logic [`EE_DATA_WIDTH-1:0] exp_data [$];
    int                        n_cmds;
    int                        ack_count;
    int                        frame_count;
    int                        value_errors;
    int                        frame_errors;
    int                        count_errors;
    int                        bit_cnt;
    int                        rst_cycles;
    logic                      in_frame;
    logic [`EE_DATA_WIDTH-1:0] shreg;

    // device code, then addr[10:8], then the direction bit
    function automatic int ctrl_token(input logic [`EE_ADDR_WIDTH-1:0] a, input rw_e rw);
        return int'({`EE_DEVICE_CODE, a[`EE_ADDR_WIDTH-1 -: `EE_BLOCK_WIDTH], rw == rw_read});
    endfunction

    task automatic load_expected();
        int    fd;
        string line;
        byte   op;
        logic [`EE_ADDR_WIDTH-1:0] a;
        logic [`EE_DATA_WIDTH-1:0] d;
        fd = $fopen("tests/eeprom_testdata.txt", "r");
        if (fd == 0)
        begin
            $display("checker could not open tests/eeprom_testdata.txt");
            count_errors++;
        end
        else
        begin
            while ($fgets(line, fd) != 0)
            begin
                if (line.len() > 2 && line[0] != "/")
                begin
                    void'($sscanf(line, "%c %h %h", op, a, d));
                    if (op == "W" || op == "R")
                    begin
                        n_cmds++;
                        exp_read.push_back(op == "R");
                        exp_data.push_back(d);
                        exp_tok.push_back(tok_start);
                        exp_tok.push_back(ctrl_token(a, rw_write));
                        exp_tok.push_back(int'(a[7:0]));
                        if (op == "R")
                        begin
                            exp_tok.push_back(tok_start);   // repeated start
                            exp_tok.push_back(ctrl_token(a, rw_read));
                        end
                        exp_tok.push_back(int'(d));
                        exp_tok.push_back(tok_stop);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic take_token(input int t);
        int e;
        if (exp_tok.size() == 0)
        begin
            $display("[ERROR] %0t: unexpected bus token %0h", $time, t);
            frame_errors++;
        end
        else
        begin
            e = exp_tok.pop_front();
            if (e != t)
            begin
                $display("[ERROR] %0t: bus token %0h, expected %0h", $time, t, e);
                frame_errors++;
            end
        end
    endtask

    task automatic check_idle_pins();
        if (ack !== 1'b0 || scl !== 1'b0 || sda !== 1'b1)
        begin
            $display("[ERROR] %0t: reset state ack=%b scl=%b sda=%b", $time, ack, scl, sda);
            value_errors++;
        end
    endtask

    initial
    begin
        n_cmds       = 0;
        ack_count    = 0;
        frame_count  = 0;
        value_errors = 0;
        frame_errors = 0;
        count_errors = 0;
        bit_cnt      = 0;
        rst_cycles   = 0;
        in_frame     = 1'b0;
        load_expected();
    end

    always @(negedge sda)
        if (scl === 1'b1 && !RESET && sda === 1'b0)
        begin
            take_token(tok_start);
            in_frame = 1'b1;
            bit_cnt  = 0;
        end

    always @(posedge sda)
        if (scl === 1'b1 && !RESET && in_frame && sda === 1'b1)
        begin
            take_token(tok_stop);
            frame_count++;
            in_frame = 1'b0;
        end

    always @(posedge scl)
        if (in_frame)
        begin
            shreg = {shreg[`EE_DATA_WIDTH-2:0], sda === 1'b1};
            bit_cnt++;
            if (bit_cnt == `EE_DATA_WIDTH)
            begin
                bit_cnt = 0;
                take_token(int'(shreg));
            end
        end

    // scl starts running half a clock after release
    always @(negedge RESET)
        check_idle_pins();

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            rst_cycles++;
            if (rst_cycles > 2)
                check_idle_pins();
        end
        else if (ack === 1'b1)
        begin
            ack_count++;
            if (exp_read.size() > 0)
            begin
                if (exp_read.pop_front() && rd_data !== exp_data[0])
                begin
                    $display("[ERROR] %0t: rd_data %0h, expected %0h",
                             $time, rd_data, exp_data[0]);
                    value_errors++;
                end
                void'(exp_data.pop_front());
            end
        end
    end

    task automatic final_checks();
        if (ack_count != n_cmds)
        begin
            $display("saw %0d ack pulses but the file has %0d commands", ack_count, n_cmds);
            count_errors++;
        end
        if (frame_count != n_cmds)
        begin
            $display("saw %0d bus frames but the file has %0d commands", frame_count, n_cmds);
            count_errors++;
        end
        if (exp_tok.size() != 0)
        begin
            $display("%0d expected bus tokens never appeared", exp_tok.size());
            count_errors++;
        end
    endtask

endmodule

//--- tests/eeprom_ctrl_tb.sv
`timescale 1ns/1ps
`include "eeprom_params.svh"

module eeprom_ctrl_tb;

    localparam int max_lines = 64;

    logic                      CLK;
    logic                      RESET;
    logic                      wr;
    logic                      rd;
    logic [`EE_ADDR_WIDTH-1:0] addr;
    logic [`EE_DATA_WIDTH-1:0] wr_data;
    wire  [`EE_DATA_WIDTH-1:0] rd_data;
    wire                       ack;
    wire                       scl;
    wire                       sda;

    byte                       cmd_op   [max_lines];
    logic [`EE_ADDR_WIDTH-1:0] cmd_addr [max_lines];
    logic [`EE_DATA_WIDTH-1:0] cmd_data [max_lines];
    int                        n_lines;
    int                        cycles;
    int                        cycle_limit;

    pullup (sda);

    eeprom_ctrl_top dut (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .rd_data (rd_data),
        .ack     (ack),
        .scl     (scl),
        .sda     (sda)
    );

    eeprom_model mem_model (
        .scl (scl),
        .sda (sda)
    );

    eeprom_checker chk (
        .CLK     (CLK),
        .RESET   (RESET),
        .ack     (ack),
        .rd_data (rd_data),
        .scl     (scl),
        .sda     (sda)
    );

    initial
    begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    task automatic load_commands();
        int    fd;
        string line;
        byte   op;
        logic [`EE_ADDR_WIDTH-1:0] a;
        logic [`EE_DATA_WIDTH-1:0] d;
        n_lines = 0;
        fd = $fopen("tests/eeprom_testdata.txt", "r");
        if (fd == 0)
            $display("could not open tests/eeprom_testdata.txt");
        else
        begin
            while ($fgets(line, fd) != 0)
            begin
                if (line.len() > 2 && line[0] != "/")
                begin
                    void'($sscanf(line, "%c %h %h", op, a, d));
                    cmd_op[n_lines]   = op;
                    cmd_addr[n_lines] = a;
                    cmd_data[n_lines] = d;
                    n_lines++;
                end
            end
            $fclose(fd);
        end
    endtask

    // one-cycle strobe with address and data
    task automatic pulse_cmd(input byte op, input logic [`EE_ADDR_WIDTH-1:0] a,
                             input logic [`EE_DATA_WIDTH-1:0] d);
        @(posedge CLK);
        if (op == "R")
            rd <= 1'b1;
        else
            wr <= 1'b1;
        addr    <= a;
        wr_data <= d;
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
    endtask

    task automatic wait_ack();
        do
            @(posedge CLK);
        while (ack !== 1'b1);
    endtask

    // cycle budget, ends a hung run
    initial
    begin
        cycles = 0;
        while (cycle_limit == 0 || cycles <= cycle_limit)
        begin
            @(posedge CLK);
            cycles++;
        end
        $display("timeout after %0d cycles, a transaction never finished", cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial
    begin
        int   total;
        logic busy_pend;
        int   busy_idx;
        RESET     = 1'b1;
        wr        = 1'b0;
        rd        = 1'b0;
        addr      = '0;
        wr_data   = '0;
        busy_pend = 1'b0;
        busy_idx  = 0;
        load_commands();
        cycle_limit = 16 + 250 * n_lines;
        repeat (16) @(posedge CLK);
        RESET <= 1'b0;
        repeat (4) @(posedge CLK);
        for (int i = 0; i < n_lines; i++)
        begin
            if (cmd_op[i] == "B")
            begin
                busy_pend = 1'b1;       // fires inside the next transaction
                busy_idx  = i;
            end
            else
            begin
                pulse_cmd(cmd_op[i], cmd_addr[i], cmd_data[i]);
                if (busy_pend)
                begin
                    repeat (20) @(posedge CLK);
                    pulse_cmd("W", cmd_addr[busy_idx], cmd_data[busy_idx]);
                    busy_pend = 1'b0;
                end
                wait_ack();
            end
        end
        repeat (10) @(posedge CLK);
        chk.final_checks();
        total = chk.value_errors + chk.frame_errors + chk.count_errors;
        $display("errors: %0d value, %0d frame, %0d count",
                 chk.value_errors, chk.frame_errors, chk.count_errors);
        if (total == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- tests/eeprom_testdata.txt
// op addr data : W write, R read with expected data, B write pulsed while busy
// addr is 3 hex digits (11 bits), data is 2 hex digits
W 000 11
R 000 11
W 155 22
W 255 33
W 355 44
W 455 55
W 555 66
W 655 77
W 755 88
R 155 22
R 255 33
R 355 44
R 455 55
R 555 66
R 655 77
R 755 88
R 055 ff
B 3c0 99
W 3c1 5a
R 3c0 ff
R 3c1 5a

//--- eeprom_ctrl.f
+incdir+source
source/eeprom_bus_pkg.sv
source/eeprom_ctrl_pkg.sv
source/serial_cmd_if.sv
source/eeprom_sequencer.sv
source/serial_bit_engine.sv
source/eeprom_ctrl_top.sv
tests/eeprom_model.sv
tests/eeprom_checker.sv
tests/eeprom_ctrl_tb.sv

//--- Bender.yml
package:
  name: eeprom_ctrl

export_include_dirs:
  - source

sources:
  - files:
      - source/eeprom_bus_pkg.sv
      - source/eeprom_ctrl_pkg.sv
      - source/serial_cmd_if.sv
      - source/eeprom_sequencer.sv
      - source/serial_bit_engine.sv
      - source/eeprom_ctrl_top.sv
  - target: test
    files:
      - tests/eeprom_model.sv
      - tests/eeprom_checker.sv
      - tests/eeprom_ctrl_tb.sv
